//--- proc_macros.svh
/*
 * Width, register count and reset PC for the processor.
 * Include in any file that sizes data, addresses or register indices.
 */

`ifndef PROC_MACROS_SVH
`define PROC_MACROS_SVH

// Data and address width
`define PROC_XLEN 32

// Architectural registers, r0 reads as zero
`define PROC_NREGS 32

// First fetch address after reset
`define PROC_RESET_PC 32'h0000_0200

`endif

//--- proc_pkg.sv
/*
 * Shared types for the processor: primary opcodes, the two views
 * of an instruction word, and the decoded operation kind.
 */

package proc_pkg;

  // --------------------------------------------------
  // Primary opcode field
  // --------------------------------------------------

  typedef enum logic [5:0] {
    SPECIAL = 6'h00,
    BNE     = 6'h05,
    ADDIU   = 6'h09,
    COP0    = 6'h10,
    LW      = 6'h23,
    SW      = 6'h2b
  } opcode_e;

  // --------------------------------------------------
  // Instruction word, R-type and I-type views
  // --------------------------------------------------

  typedef struct packed {
    opcode_e     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [5:0]  funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_e     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } inst_u;

  // Decoded operation handed from decode onwards
  typedef enum logic [2:0] {
    OP_ADDU, OP_ADDIU, OP_LW, OP_SW, OP_BNE, OP_MFC0, OP_MTC0
  } op_kind_e;

endpackage

//--- proc_decode.sv
/*
 * Fetch and decode. Holds the PC, fetches one word over the imem
 * channels, decodes it and waits for retire before fetching again.
 */

`timescale 1ns/1ps
`include "proc_macros.svh"

module proc_decode
(
  input  logic                             clk,
  input  logic                             reset,

  output logic [`PROC_XLEN-1:0]            imemreq_addr,
  output logic                             imemreq_val,
  input  logic                             imemreq_rdy,

  input  logic [`PROC_XLEN-1:0]            imemresp_data,
  input  logic                             imemresp_val,
  output logic                             imemresp_rdy,

  output logic                             dx_val,
  input  logic                             dx_rdy,
  output proc_pkg::op_kind_e               dx_op,
  output logic [$clog2(`PROC_NREGS)-1:0]   dx_rs,
  output logic [$clog2(`PROC_NREGS)-1:0]   dx_rt,
  output logic [$clog2(`PROC_NREGS)-1:0]   dx_rd,
  output logic [`PROC_XLEN-1:0]            dx_imm,
  output logic [`PROC_XLEN-1:0]            dx_pc,

  input  logic                             redirect,
  input  logic [`PROC_XLEN-1:0]            redirect_pc,
  input  logic                             retire
);

  import proc_pkg::*;

  typedef enum logic [1:0] {FETCH, WAIT, ISSUE} state_e;

  state_e                 state;
  logic [`PROC_XLEN-1:0]  pc;
  logic                   redir_q;
  inst_u                  inst_q;

  assign imemreq_addr = pc;
  assign imemresp_rdy = (state == WAIT);
  assign dx_pc        = pc;

  // --------------------------------------------------
  // Fetch FSM
  // --------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= FETCH;
      pc          <= `PROC_RESET_PC;
      imemreq_val <= 1'b0;
      dx_val      <= 1'b0;
      redir_q     <= 1'b0;
    end
    else
    begin
      case (state)
        FETCH:
        begin
          // Only reached with val low straight out of reset
          if (!imemreq_val)
            imemreq_val <= 1'b1;
          else if (imemreq_rdy)
          begin
            imemreq_val <= 1'b0;
            state       <= WAIT;
          end
        end
        WAIT:
        begin
          if (imemresp_val)
          begin
            dx_val <= 1'b1;
            state  <= ISSUE;
          end
        end
        default:
        begin
          if (dx_val && dx_rdy)
            dx_val <= 1'b0;
          // Taken branch target lands in the PC before retire
          if (redirect)
          begin
            pc      <= redirect_pc;
            redir_q <= 1'b1;
          end
          if (retire)
          begin
            state       <= FETCH;
            imemreq_val <= 1'b1;
            redir_q     <= 1'b0;
            if (!redir_q)
              pc <= pc + `PROC_XLEN'(4);
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (imemresp_val && imemresp_rdy)
      inst_q <= imemresp_data;
  end

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------

  assign dx_rs  = inst_q.r_fmt.rs;
  assign dx_rt  = inst_q.r_fmt.rt;
  assign dx_imm = {{(`PROC_XLEN-16){inst_q.i_fmt.imm[15]}}, inst_q.i_fmt.imm};

  // Anything outside the subset becomes addu into r0
  always_comb
  begin
    dx_op = OP_ADDU;
    dx_rd = '0;
    case (inst_q.r_fmt.opcode)
      SPECIAL:
        if (inst_q.r_fmt.funct == 6'h21)
          dx_rd = inst_q.r_fmt.rd;
      ADDIU:
      begin
        dx_op = OP_ADDIU;
        dx_rd = inst_q.i_fmt.rt;
      end
      LW:
      begin
        dx_op = OP_LW;
        dx_rd = inst_q.i_fmt.rt;
      end
      SW:  dx_op = OP_SW;
      BNE: dx_op = OP_BNE;
      COP0:
      begin
        if (inst_q.r_fmt.rs == 5'd0)
        begin
          dx_op = OP_MFC0;
          dx_rd = inst_q.r_fmt.rt;
        end
        else if (inst_q.r_fmt.rs == 5'd4)
          dx_op = OP_MTC0;
      end
      default: dx_op = OP_ADDU;
    endcase
  end

  imem_addr_aligned: assert property (@(posedge clk) disable iff (reset)
    imemreq_val |-> imemreq_addr[1:0] == 2'b00);

endmodule

//--- proc_execute.sv
/*
 * Execute stage. Reads operands, adds, resolves bne, and issues the
 * dmem request or from_mngr read before handing a result on.
 */

`timescale 1ns/1ps
`include "proc_macros.svh"

module proc_execute
(
  input  logic                             clk,
  input  logic                             reset,

  input  logic                             dx_val,
  output logic                             dx_rdy,
  input  proc_pkg::op_kind_e               dx_op,
  input  logic [$clog2(`PROC_NREGS)-1:0]   dx_rs,
  input  logic [$clog2(`PROC_NREGS)-1:0]   dx_rt,
  input  logic [$clog2(`PROC_NREGS)-1:0]   dx_rd,
  input  logic [`PROC_XLEN-1:0]            dx_imm,
  input  logic [`PROC_XLEN-1:0]            dx_pc,

  output logic [$clog2(`PROC_NREGS)-1:0]   rf_raddr0,
  output logic [$clog2(`PROC_NREGS)-1:0]   rf_raddr1,
  input  logic [`PROC_XLEN-1:0]            rf_rdata0,
  input  logic [`PROC_XLEN-1:0]            rf_rdata1,

  output logic                             dmemreq_write,
  output logic [`PROC_XLEN-1:0]            dmemreq_addr,
  output logic [`PROC_XLEN-1:0]            dmemreq_data,
  output logic                             dmemreq_val,
  input  logic                             dmemreq_rdy,

  input  logic [`PROC_XLEN-1:0]            from_mngr_msg,
  input  logic                             from_mngr_val,
  output logic                             from_mngr_rdy,

  output logic                             xw_val,
  input  logic                             xw_rdy,
  output proc_pkg::op_kind_e               xw_op,
  output logic [$clog2(`PROC_NREGS)-1:0]   xw_waddr,
  output logic [`PROC_XLEN-1:0]            xw_value,

  output logic                             redirect,
  output logic [`PROC_XLEN-1:0]            redirect_pc
);

  import proc_pkg::*;

  logic                   is_mem;
  logic [`PROC_XLEN-1:0]  sum;
  logic                   br_taken_q;
  logic                   dx_fire;

  assign rf_raddr0 = dx_rs;
  assign rf_raddr1 = dx_rt;

  // Second operand is rt for addu, the immediate otherwise
  assign sum    = rf_rdata0 + ((dx_op == OP_ADDU) ? rf_rdata1 : dx_imm);
  assign is_mem = (dx_op == OP_LW) || (dx_op == OP_SW);

  // --------------------------------------------------
  // Outgoing requests and dx handshake
  // --------------------------------------------------

  assign dmemreq_val   = dx_val && is_mem && !xw_val;
  assign dmemreq_write = (dx_op == OP_SW);
  assign dmemreq_addr  = sum;
  assign dmemreq_data  = rf_rdata1;
  assign from_mngr_rdy = dx_val && (dx_op == OP_MFC0) && !xw_val;

  always_comb
  begin
    if (is_mem)
      dx_rdy = dmemreq_rdy && !xw_val;
    else if (dx_op == OP_MFC0)
      dx_rdy = from_mngr_val && !xw_val;
    else
      dx_rdy = !xw_val;
  end

  assign dx_fire = dx_val && dx_rdy;

  // --------------------------------------------------
  // Result register towards result stage
  // --------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      xw_val <= 1'b0;
    else if (dx_fire)
      xw_val <= 1'b1;
    else if (xw_rdy)
      xw_val <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (dx_fire)
    begin
      xw_op       <= dx_op;
      xw_waddr    <= dx_rd;
      br_taken_q  <= (dx_op == OP_BNE) && (rf_rdata0 != rf_rdata1);
      redirect_pc <= dx_pc + `PROC_XLEN'(4) + {dx_imm[`PROC_XLEN-3:0], 2'b00};
      case (dx_op)
        OP_MFC0: xw_value <= from_mngr_msg;
        OP_MTC0: xw_value <= rf_rdata1;
        OP_BNE:  xw_value <= '0;
        default: xw_value <= sum;
      endcase
    end
  end

  // Pulse together with the bne hand-off
  assign redirect = xw_val && xw_rdy && br_taken_q;

  one_request_kind: assert property (@(posedge clk) disable iff (reset)
    !(dmemreq_val && from_mngr_rdy));

endmodule

//--- proc_result.sv
/*
 * Result stage and register file. Writes back ALU, mfc0 and load
 * values, sends mtc0 values to the manager, and pulses retire.
 */

`timescale 1ns/1ps
`include "proc_macros.svh"

module proc_result
(
  input  logic                             clk,
  input  logic                             reset,

  input  logic                             xw_val,
  output logic                             xw_rdy,
  input  proc_pkg::op_kind_e               xw_op,
  input  logic [$clog2(`PROC_NREGS)-1:0]   xw_waddr,
  input  logic [`PROC_XLEN-1:0]            xw_value,

  input  logic [`PROC_XLEN-1:0]            dmemresp_data,
  input  logic                             dmemresp_val,
  output logic                             dmemresp_rdy,

  output logic [`PROC_XLEN-1:0]            to_mngr_msg,
  output logic                             to_mngr_val,
  input  logic                             to_mngr_rdy,

  input  logic [$clog2(`PROC_NREGS)-1:0]   rf_raddr0,
  input  logic [$clog2(`PROC_NREGS)-1:0]   rf_raddr1,
  output logic [`PROC_XLEN-1:0]            rf_rdata0,
  output logic [`PROC_XLEN-1:0]            rf_rdata1,

  output logic                             retire
);

  import proc_pkg::*;

  localparam int RAW = $clog2(`PROC_NREGS);

  typedef enum logic [1:0] {IDLE, MEM, SEND} state_e;

  state_e                 state;
  logic [`PROC_XLEN-1:0]  regs [`PROC_NREGS];
  logic                   xw_fire;
  logic                   wen;
  logic [RAW-1:0]         waddr;
  logic [`PROC_XLEN-1:0]  wdata;
  logic                   wb_load_q;
  logic [RAW-1:0]         wb_addr_q;

  assign xw_rdy       = (state == IDLE);
  assign dmemresp_rdy = (state == MEM);
  assign to_mngr_val  = (state == SEND);
  assign xw_fire      = xw_val && xw_rdy;

  // --------------------------------------------------
  // Register file
  // --------------------------------------------------

  always_comb
  begin
    wen   = 1'b0;
    waddr = xw_waddr;
    wdata = xw_value;
    if (xw_fire && (xw_op == OP_ADDU || xw_op == OP_ADDIU || xw_op == OP_MFC0))
      wen = 1'b1;
    else if (dmemresp_rdy && dmemresp_val && wb_load_q)
    begin
      wen   = 1'b1;
      waddr = wb_addr_q;
      wdata = dmemresp_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wen && waddr != '0)
      regs[waddr] <= wdata;
  end

  // r0 is never written, so mask the read
  assign rf_rdata0 = (rf_raddr0 == '0) ? '0 : regs[rf_raddr0];
  assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : regs[rf_raddr1];

  // --------------------------------------------------
  // Completion FSM
  // --------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state  <= IDLE;
      retire <= 1'b0;
    end
    else
    begin
      retire <= 1'b0;
      case (state)
        IDLE:
          if (xw_fire)
          begin
            if (xw_op == OP_LW || xw_op == OP_SW)
              state <= MEM;
            else if (xw_op == OP_MTC0)
              state <= SEND;
            else
              retire <= 1'b1;
          end
        MEM:
          if (dmemresp_val)
          begin
            state  <= IDLE;
            retire <= 1'b1;
          end
        default:
          if (to_mngr_rdy)
          begin
            state  <= IDLE;
            retire <= 1'b1;
          end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (xw_fire)
    begin
      wb_load_q   <= (xw_op == OP_LW);
      wb_addr_q   <= xw_waddr;
      to_mngr_msg <= xw_value;
    end
  end

  to_mngr_stable: assert property (@(posedge clk) disable iff (reset)
    to_mngr_val && !to_mngr_rdy |=> $stable(to_mngr_msg));

endmodule

//--- proc_top.sv
/*
 * Processor top level. Joins decode, execute and result to the
 * memory and manager ports; one instruction is in flight at a time.
 */

`timescale 1ns/1ps
`include "proc_macros.svh"

module proc_top
(
  input  logic                   clk,
  input  logic                   reset,

  output logic [`PROC_XLEN-1:0]  imemreq_addr,
  output logic                   imemreq_val,
  input  logic                   imemreq_rdy,
  input  logic [`PROC_XLEN-1:0]  imemresp_data,
  input  logic                   imemresp_val,
  output logic                   imemresp_rdy,

  output logic                   dmemreq_write,
  output logic [`PROC_XLEN-1:0]  dmemreq_addr,
  output logic [`PROC_XLEN-1:0]  dmemreq_data,
  output logic                   dmemreq_val,
  input  logic                   dmemreq_rdy,
  input  logic [`PROC_XLEN-1:0]  dmemresp_data,
  input  logic                   dmemresp_val,
  output logic                   dmemresp_rdy,

  input  logic [`PROC_XLEN-1:0]  from_mngr_msg,
  input  logic                   from_mngr_val,
  output logic                   from_mngr_rdy,
  output logic [`PROC_XLEN-1:0]  to_mngr_msg,
  output logic                   to_mngr_val,
  input  logic                   to_mngr_rdy
);

  import proc_pkg::*;

  // Decode to execute
  logic                            dx_val, dx_rdy;
  op_kind_e                        dx_op;
  logic [$clog2(`PROC_NREGS)-1:0]  dx_rs, dx_rt, dx_rd;
  logic [`PROC_XLEN-1:0]           dx_imm, dx_pc;

  // Execute to result, and register reads
  logic                            xw_val, xw_rdy;
  op_kind_e                        xw_op;
  logic [$clog2(`PROC_NREGS)-1:0]  xw_waddr, rf_raddr0, rf_raddr1;
  logic [`PROC_XLEN-1:0]           xw_value, rf_rdata0, rf_rdata1;

  logic                            redirect, retire;
  logic [`PROC_XLEN-1:0]           redirect_pc;

  proc_decode decode_i (.*);
  proc_execute execute_i (.*);
  proc_result result_i (.*);

endmodule

//--- tb_proc.sv
/*
 * Testbench for proc_top. Runs a program table through memory and
 * manager models with random stalls and checks every to_mngr word.
 */

`timescale 1ns/1ps
`include "proc_macros.svh"

module tb_proc;

  localparam int TIMEOUT = 2000;
  localparam logic [31:0] MNGR_SRC [2] = '{32'd5, 32'd7};

  logic                   clk = 1'b0;
  logic                   reset;
  logic [`PROC_XLEN-1:0]  imemreq_addr;
  logic                   imemreq_val;
  logic                   imemreq_rdy;
  logic [`PROC_XLEN-1:0]  imemresp_data;
  logic                   imemresp_val;
  logic                   imemresp_rdy;
  logic                   dmemreq_write;
  logic [`PROC_XLEN-1:0]  dmemreq_addr;
  logic [`PROC_XLEN-1:0]  dmemreq_data;
  logic                   dmemreq_val;
  logic                   dmemreq_rdy;
  logic [`PROC_XLEN-1:0]  dmemresp_data;
  logic                   dmemresp_val;
  logic                   dmemresp_rdy;
  logic [`PROC_XLEN-1:0]  from_mngr_msg;
  logic                   from_mngr_val;
  logic                   from_mngr_rdy;
  logic [`PROC_XLEN-1:0]  to_mngr_msg;
  logic                   to_mngr_val;
  logic                   to_mngr_rdy;

  // Program table with one row per instruction word
  logic [31:0]  imem [64];
  logic [31:0]  exp_val [64];
  logic         exp_chk [64];
  string        exp_name [64];
  int           n_inst = 0;

  logic [31:0]  dmem [256];
  logic [31:0]  rx_q [$];
  int           fm_idx;

  // Model state sampled before each edge
  logic         im_req_fire, im_resp_fire, im_pend, first_fetch;
  logic         dm_req_fire, dm_resp_fire, dm_pend, dm_write;
  logic         fm_fire, tm_fire;
  logic [31:0]  im_addr, dm_addr, dm_data, tm_msg;
  int           im_delay, dm_delay;

  proc_top dut_i (.*);

  always #20 clk = ~clk;

  // --------------------------------------------------
  // Instruction encoding and checks
  // --------------------------------------------------

  function automatic logic [31:0] itype_word(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                             logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] addu_word(logic [4:0] rd, logic [4:0] rs, logic [4:0] rt);
    return {6'h00, rs, rt, rd, 5'd0, 6'h21};
  endfunction

  // sel 0 is mfc0 into rt and sel 4 is mtc0 from rt
  function automatic logic [31:0] cop0_word(logic [4:0] sel, logic [4:0] rt);
    return {6'h10, sel, rt, 16'h0000};
  endfunction

  function automatic logic [31:0] fetch_word(logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - `PROC_RESET_PC) >> 2;
    if (idx < 32'(n_inst))
      return imem[idx[5:0]];
    return 32'h0;
  endfunction

  task automatic add_entry(input logic [31:0] word, input logic chk,
                           input logic [31:0] value, input string name);
    imem[n_inst]     = word;
    exp_chk[n_inst]  = chk;
    exp_val[n_inst]  = value;
    exp_name[n_inst] = name;
    n_inst++;
  endtask

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("Fail %s expected %h actual %h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "Wrong value in %s", name);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out waiting for the to_mngr word of %s", what);
    $display("TESTS FAILED");
    $fatal(1, "Timeout");
  endtask

  // --------------------------------------------------
  // Memory and manager models
  // --------------------------------------------------

  initial
  begin
    int unsigned seed;
    seed          = $urandom(32'h87cd);
    imemreq_rdy   = 1'b0;
    imemresp_data = 32'h0;
    imemresp_val  = 1'b0;
    dmemreq_rdy   = 1'b0;
    dmemresp_data = 32'h0;
    dmemresp_val  = 1'b0;
    from_mngr_msg = 32'h0;
    from_mngr_val = 1'b0;
    to_mngr_rdy   = 1'b0;
    fm_idx        = 0;
    im_pend       = 1'b0;
    dm_pend       = 1'b0;
    first_fetch   = 1'b1;
    for (int a = 0; a < 256; a++)
      dmem[a] = 32'h5a5a_0000 ^ (32'(a) << 2);
    forever
    begin
      @(negedge clk);
      im_req_fire  = !reset && imemreq_val && imemreq_rdy;
      im_resp_fire = !reset && imemresp_val && imemresp_rdy;
      dm_req_fire  = !reset && dmemreq_val && dmemreq_rdy;
      dm_resp_fire = !reset && dmemresp_val && dmemresp_rdy;
      fm_fire      = !reset && from_mngr_val && from_mngr_rdy;
      tm_fire      = !reset && to_mngr_val && to_mngr_rdy;
      if (im_req_fire)
        im_addr = imemreq_addr;
      if (dm_req_fire)
      begin
        dm_addr  = dmemreq_addr;
        dm_data  = dmemreq_data;
        dm_write = dmemreq_write;
      end
      tm_msg = to_mngr_msg;
      @(posedge clk);
      #1;
      if (im_req_fire && first_fetch)
      begin
        check_word("reset_pc", `PROC_RESET_PC, im_addr);
        first_fetch = 1'b0;
      end
      if (im_resp_fire)
      begin
        imemresp_val = 1'b0;
        im_pend      = 1'b0;
      end
      if (im_req_fire)
      begin
        im_pend  = 1'b1;
        im_delay = $urandom % 3;
      end
      if (im_pend && !imemresp_val)
      begin
        if (im_delay == 0)
        begin
          imemresp_val  = 1'b1;
          imemresp_data = fetch_word(im_addr);
        end
        else
          im_delay--;
      end
      if (dm_resp_fire)
      begin
        dmemresp_val = 1'b0;
        dm_pend      = 1'b0;
      end
      if (dm_req_fire)
      begin
        if (dm_write)
          dmem[dm_addr[9:2]] = dm_data;
        dm_pend  = 1'b1;
        dm_delay = $urandom % 3;
      end
      if (dm_pend && !dmemresp_val)
      begin
        if (dm_delay == 0)
        begin
          dmemresp_val  = 1'b1;
          dmemresp_data = dm_write ? 32'h0 : dmem[dm_addr[9:2]];
        end
        else
          dm_delay--;
      end
      if (fm_fire)
        fm_idx++;
      from_mngr_val = (fm_idx < 2);
      if (fm_idx < 2)
        from_mngr_msg = MNGR_SRC[fm_idx];
      if (tm_fire)
        rx_q.push_back(tm_msg);
      imemreq_rdy = ($urandom % 4) != 0;
      dmemreq_rdy = ($urandom % 4) != 0;
      to_mngr_rdy = ($urandom % 3) != 0;
    end
  end

  // --------------------------------------------------
  // Program, reset and expected to_mngr words
  // --------------------------------------------------

  initial
  begin
    int          cycles;
    int          rd_idx;
    reset = 1'b1;

    // Operands 5 and 7 come in from the manager
    add_entry(cop0_word(5'd0, 5'd1), 1'b0, 32'h0, "mfc0_r1");
    add_entry(cop0_word(5'd0, 5'd2), 1'b0, 32'h0, "mfc0_r2");
    add_entry(addu_word(5'd3, 5'd1, 5'd2), 1'b0, 32'h0, "addu_r3");
    add_entry(cop0_word(5'd4, 5'd3), 1'b1, 32'd12, "addu_sum");
    add_entry(itype_word(6'h09, 5'd3, 5'd4, 16'hfffd), 1'b0, 32'h0, "addiu_r4");
    add_entry(cop0_word(5'd4, 5'd4), 1'b1, 32'd9, "addiu_negative");
    add_entry(addu_word(5'd0, 5'd1, 5'd2), 1'b0, 32'h0, "addu_r0");
    add_entry(cop0_word(5'd4, 5'd0), 1'b1, 32'd0, "r0_stays_zero");
    add_entry(itype_word(6'h09, 5'd0, 5'd5, 16'h0100), 1'b0, 32'h0, "addiu_base");
    add_entry(itype_word(6'h2b, 5'd5, 5'd3, 16'h0004), 1'b0, 32'h0, "sw_r3");
    add_entry(itype_word(6'h23, 5'd5, 5'd6, 16'h0004), 1'b0, 32'h0, "lw_r6");
    add_entry(cop0_word(5'd4, 5'd6), 1'b1, 32'd12, "sw_then_lw");
    add_entry(itype_word(6'h23, 5'd5, 5'd7, 16'h0000), 1'b0, 32'h0, "lw_r7");
    add_entry(cop0_word(5'd4, 5'd7), 1'b1, 32'h5a5a_0100, "lw_preloaded");
    add_entry(itype_word(6'h05, 5'd1, 5'd2, 16'h0001), 1'b0, 32'h0, "bne_taken");
    add_entry(cop0_word(5'd4, 5'd1), 1'b0, 32'h0, "skipped_by_bne");
    add_entry(itype_word(6'h05, 5'd1, 5'd1, 16'h0001), 1'b0, 32'h0, "bne_not_taken");
    add_entry(cop0_word(5'd4, 5'd2), 1'b1, 32'd7, "bne_fallthrough");
    add_entry(itype_word(6'h09, 5'd0, 5'd8, 16'hffff), 1'b0, 32'h0, "addiu_minus_one");
    add_entry(addu_word(5'd9, 5'd8, 5'd2), 1'b0, 32'h0, "addu_r9");
    add_entry(cop0_word(5'd4, 5'd9), 1'b1, 32'd6, "addu_wraps");
    // Spins on itself for the rest of the run
    add_entry(itype_word(6'h05, 5'd1, 5'd0, 16'hffff), 1'b0, 32'h0, "bne_self_loop");

    @(posedge clk);
    @(negedge clk);
    check_word("reset_outputs", 32'h0, {29'h0, imemreq_val, dmemreq_val, to_mngr_val});
    @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_word("after_reset", 32'h0, {29'h0, imemreq_val, dmemreq_val, to_mngr_val});

    rd_idx = 0;
    for (int i = 0; i < n_inst; i++)
    begin
      if (exp_chk[i])
      begin
        cycles = 0;
        while (rx_q.size() <= rd_idx)
        begin
          @(posedge clk);
          cycles++;
          assert (cycles < TIMEOUT) else stop_on_timeout(exp_name[i]);
        end
        check_word(exp_name[i], exp_val[i], rx_q[rd_idx]);
        rd_idx++;
      end
    end

    // Nothing more may reach the manager while the loop spins
    repeat (80) @(posedge clk);
    check_word("no_extra_msgs", 32'(rd_idx), 32'(rx_q.size()));
    check_word("mngr_reads", 32'd2, 32'(fm_idx));
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- src.f
+incdir+.
proc_pkg.sv
proc_decode.sv
proc_execute.sv
proc_result.sv
proc_top.sv
tb_proc.sv

//--- run.sh
#!/usr/bin/env bash
# Build the processor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_proc -f src.f -o sim_proc; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_proc
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished cleanly"
exit 0
